// File: filelist.f
icache_pkg.sv
icache_lookup.sv
icache_arrays.sv
icache_verify.sv
icache.sv
tb_icache.sv

// File: icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache
  import icache_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_i,

  input  logic                          fetch_v_i,
  input  logic [vaddr_width-1:0]        vaddr_i,
  output logic                          fetch_ready_o,

  input  logic [ptag_width-1:0]         ptag_i,
  input  logic                          ptag_v_i,

  output logic [word_width-1:0]         data_o,
  output logic                          data_v_o,
  output logic                          miss_o,

  output logic                          cache_req_v_o,
  output logic [block_addr_width-1:0]   cache_req_addr_o,
  output logic [way_width-1:0]          cache_req_way_o,
  input  logic                          cache_req_complete_i,

  input  logic                          fill_v_i,
  input  logic [index_width-1:0]        fill_index_i,
  input  logic [way_width-1:0]          fill_way_i,
  input  logic [tag_width-1:0]          fill_tag_i,
  input  logic [block_width-1:0]        fill_data_i
);

  logic                                 rd_v;
  logic [index_width-1:0]               rd_index;
  logic                                 wr_v;
  logic [index_width-1:0]               wr_index;
  logic [way_width-1:0]                 wr_way;
  logic [tag_width-1:0]                 wr_tag;
  logic [block_width-1:0]               wr_data;
  logic                                 lookup_v;
  logic [page_offset_width-1:0]         page_offset;
  logic [num_ways-1:0][tag_width-1:0]   tags;
  logic [num_ways-1:0]                  valid;
  logic [num_ways-1:0][block_width-1:0] blocks;
  logic [way_width-1:0]                 lru;
  logic                                 lru_v;
  logic [index_width-1:0]               lru_index;
  logic [way_width-1:0]                 lru_way;
  logic                                 kill;

  icache_lookup lookup_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fetch_v_i      (fetch_v_i),
    .vaddr_i        (vaddr_i),
    .fill_v_i       (fill_v_i),
    .fill_index_i   (fill_index_i),
    .fill_way_i     (fill_way_i),
    .fill_tag_i     (fill_tag_i),
    .fill_data_i    (fill_data_i),
    .kill_i         (kill),
    .miss_pending_i (miss_o),
    .req_v_i        (cache_req_v_o),
    .fetch_ready_o  (fetch_ready_o),
    .rd_v_o         (rd_v),
    .rd_index_o     (rd_index),
    .wr_v_o         (wr_v),
    .wr_index_o     (wr_index),
    .wr_way_o       (wr_way),
    .wr_tag_o       (wr_tag),
    .wr_data_o      (wr_data),
    .lookup_v_o     (lookup_v),
    .page_offset_o  (page_offset)
  );

  icache_arrays arrays_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .rd_v_i      (rd_v),
    .rd_index_i  (rd_index),
    .wr_v_i      (wr_v),
    .wr_index_i  (wr_index),
    .wr_way_i    (wr_way),
    .wr_tag_i    (wr_tag),
    .wr_data_i   (wr_data),
    .lru_v_i     (lru_v),
    .lru_index_i (lru_index),
    .lru_way_i   (lru_way),
    .tags_o      (tags),
    .valid_o     (valid),
    .blocks_o    (blocks),
    .lru_o       (lru)
  );

  icache_verify verify_i (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .lookup_v_i           (lookup_v),
    .page_offset_i        (page_offset),
    .ptag_i               (ptag_i),
    .ptag_v_i             (ptag_v_i),
    .tags_i               (tags),
    .valid_i              (valid),
    .blocks_i             (blocks),
    .lru_i                (lru),
    .cache_req_complete_i (cache_req_complete_i),
    .data_o               (data_o),
    .data_v_o             (data_v_o),
    .cache_req_v_o        (cache_req_v_o),
    .cache_req_addr_o     (cache_req_addr_o),
    .cache_req_way_o      (cache_req_way_o),
    .miss_o               (miss_o),
    .kill_o               (kill),
    .lru_v_o              (lru_v),
    .lru_index_o          (lru_index),
    .lru_way_o            (lru_way)
  );

endmodule

`default_nettype wire

// File: icache_arrays.sv
`timescale 1ns/1ps
`default_nettype none

module icache_arrays
  import icache_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  reset_i,

  input  logic                                  rd_v_i,
  input  logic [index_width-1:0]                rd_index_i,

  input  logic                                  wr_v_i,
  input  logic [index_width-1:0]                wr_index_i,
  input  logic [way_width-1:0]                  wr_way_i,
  input  logic [tag_width-1:0]                  wr_tag_i,
  input  logic [block_width-1:0]                wr_data_i,

  input  logic                                  lru_v_i,
  input  logic [index_width-1:0]                lru_index_i,
  input  logic [way_width-1:0]                  lru_way_i,

  output logic [num_ways-1:0][tag_width-1:0]    tags_o,
  output logic [num_ways-1:0]                   valid_o,
  output logic [num_ways-1:0][block_width-1:0]  blocks_o,
  output logic [way_width-1:0]                  lru_o
);

  // one row per set in each way
  logic [tag_width-1:0]   tag_mem  [num_ways][num_sets];
  logic [block_width-1:0] data_mem [num_ways][num_sets];

  logic [num_sets-1:0][num_ways-1:0]  valid_r;
  logic [num_sets-1:0][way_width-1:0] lru_r;

  // fill writes tag and whole block of one way
  always_ff @(posedge clk_i) begin
    if (wr_v_i) begin
      tag_mem[wr_way_i][wr_index_i]  <= wr_tag_i;
      data_mem[wr_way_i][wr_index_i] <= wr_data_i;
    end
  end

  // per-set valid and lru bits
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= '0;
      lru_r   <= '0;
    end else begin
      if (wr_v_i) begin
        valid_r[wr_index_i][wr_way_i] <= 1'b1;
      end
      // records the way that hit most recently
      if (lru_v_i) begin
        lru_r[lru_index_i] <= lru_way_i;
      end
    end
  end

  // synchronous read of the whole set
  always_ff @(posedge clk_i) begin
    if (rd_v_i) begin
      for (int w = 0; w < num_ways; w++) begin
        tags_o[w]   <= tag_mem[w][rd_index_i];
        blocks_o[w] <= data_mem[w][rd_index_i];
      end
      valid_o <= valid_r[rd_index_i];
      lru_o   <= lru_r[rd_index_i];
    end
  end

endmodule

`default_nettype wire

// File: icache_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module icache_lookup
  import icache_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,

  input  logic                         fetch_v_i,
  input  logic [vaddr_width-1:0]       vaddr_i,

  input  logic                         fill_v_i,
  input  logic [index_width-1:0]       fill_index_i,
  input  logic [way_width-1:0]         fill_way_i,
  input  logic [tag_width-1:0]         fill_tag_i,
  input  logic [block_width-1:0]       fill_data_i,

  input  logic                         kill_i,
  input  logic                         miss_pending_i,
  input  logic                         req_v_i,

  output logic                         fetch_ready_o,

  output logic                         rd_v_o,
  output logic [index_width-1:0]       rd_index_o,

  output logic                         wr_v_o,
  output logic [index_width-1:0]       wr_index_o,
  output logic [way_width-1:0]         wr_way_o,
  output logic [tag_width-1:0]         wr_tag_o,
  output logic [block_width-1:0]       wr_data_o,

  output logic                         lookup_v_o,
  output logic [page_offset_width-1:0] page_offset_o
);

  logic                         accept;
  logic                         lookup_v_r;
  logic [page_offset_width-1:0] page_offset_r;

  // no new fetch while a miss is being requested or is outstanding
  assign fetch_ready_o = ~miss_pending_i & ~req_v_i;
  assign accept        = fetch_v_i & fetch_ready_o;

  // index the arrays straight from the virtual address
  assign rd_v_o     = accept;
  assign rd_index_o = vaddr_i[block_offset_width +: index_width];

  // fills only come while a miss is pending, so they never collide with a read
  assign wr_v_o     = fill_v_i;
  assign wr_index_o = fill_index_i;
  assign wr_way_o   = fill_way_i;
  assign wr_tag_o   = fill_tag_i;
  assign wr_data_o  = fill_data_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lookup_v_r <= 1'b0;
    end else begin
      lookup_v_r <= accept;
    end
  end

  // page offset is untranslated and is carried along to the verify stage
  always_ff @(posedge clk_i) begin
    if (accept) begin
      page_offset_r <= vaddr_i[page_offset_width-1:0];
    end
  end

  // a miss in verify squashes the younger fetch sitting here
  assign lookup_v_o    = lookup_v_r & ~kill_i;
  assign page_offset_o = page_offset_r;

endmodule

`default_nettype wire

// File: icache_pkg.sv
`default_nettype none

package icache_pkg;

  // address widths
  localparam int vaddr_width       = 16;
  localparam int paddr_width       = 20;
  localparam int page_offset_width = 12;
  localparam int ptag_width        = paddr_width - page_offset_width;

  // set and way geometry
  localparam int num_sets    = 16;
  localparam int num_ways    = 2;
  localparam int way_width   = 1;
  localparam int index_width = 4;

  // block layout
  localparam int word_width         = 32;
  localparam int block_words        = 4;
  localparam int word_sel_width     = 2;
  localparam int block_offset_width = 4;
  localparam int block_width        = word_width * block_words;

  // byte offset inside one instruction word
  localparam int word_offset_width = block_offset_width - word_sel_width;

  // index and block offset both sit inside the page offset, so the set
  // can be read before translation finishes
  localparam int tag_width        = paddr_width - index_width - block_offset_width;
  localparam int block_addr_width = paddr_width - block_offset_width;

endpackage

`default_nettype wire

// File: icache_verify.sv
`timescale 1ns/1ps
`default_nettype none

module icache_verify
  import icache_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  reset_i,

  input  logic                                  lookup_v_i,
  input  logic [page_offset_width-1:0]          page_offset_i,
  input  logic [ptag_width-1:0]                 ptag_i,
  input  logic                                  ptag_v_i,

  input  logic [num_ways-1:0][tag_width-1:0]    tags_i,
  input  logic [num_ways-1:0]                   valid_i,
  input  logic [num_ways-1:0][block_width-1:0]  blocks_i,
  input  logic [way_width-1:0]                  lru_i,

  input  logic                                  cache_req_complete_i,

  output logic [word_width-1:0]                 data_o,
  output logic                                  data_v_o,
  output logic                                  cache_req_v_o,
  output logic [block_addr_width-1:0]           cache_req_addr_o,
  output logic [way_width-1:0]                  cache_req_way_o,
  output logic                                  miss_o,
  output logic                                  kill_o,

  output logic                                  lru_v_o,
  output logic [index_width-1:0]                lru_index_o,
  output logic [way_width-1:0]                  lru_way_o
);

  logic [paddr_width-1:0]                   paddr;
  logic [tag_width-1:0]                     addr_tag;
  logic [index_width-1:0]                   addr_index;
  logic [word_sel_width-1:0]                addr_word;
  logic                                     tv_we;

  logic [num_ways-1:0]                      hit;
  logic                                     hit_any;
  logic [way_width-1:0]                     hit_way;
  logic [way_width-1:0]                     invalid_way;
  logic [way_width-1:0]                     repl_way;
  logic [block_words-1:0][word_width-1:0]   hit_block;
  logic [word_width-1:0]                    hit_word;

  logic                                     data_v_r;
  logic                                     req_v_r;
  logic                                     miss_r;
  logic [word_width-1:0]                    data_r;
  logic [block_addr_width-1:0]              req_addr_r;
  logic [way_width-1:0]                     req_way_r;
  logic [index_width-1:0]                   index_r;
  logic [way_width-1:0]                     hit_way_r;

  // physical address from the late tag and the carried page offset
  assign paddr      = {ptag_i, page_offset_i};
  assign addr_tag   = paddr[paddr_width-1 -: tag_width];
  assign addr_index = paddr[block_offset_width +: index_width];
  assign addr_word  = paddr[word_offset_width +: word_sel_width];

  // a fetch without a valid ptag is dropped here
  assign tv_we = lookup_v_i & ptag_v_i;

  always_comb begin
    hit_way     = '0;
    invalid_way = '0;
    for (int w = 0; w < num_ways; w++) begin
      hit[w] = valid_i[w] & (tags_i[w] == addr_tag);
    end
    // walk down so the lowest way wins
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (hit[w]) begin
        hit_way = way_width'(w);
      end
      if (!valid_i[w]) begin
        invalid_way = way_width'(w);
      end
    end
  end

  assign hit_any = |hit;

  // an empty way beats the lru choice
  assign repl_way = (~&valid_i) ? invalid_way : ~lru_i;

  assign hit_block = blocks_i[hit_way];
  assign hit_word  = hit_block[addr_word];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      data_v_r <= 1'b0;
      req_v_r  <= 1'b0;
    end else begin
      data_v_r <= tv_we & hit_any;
      req_v_r  <= tv_we & ~hit_any;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tv_we) begin
      data_r     <= hit_word;
      req_addr_r <= paddr[paddr_width-1:block_offset_width];
      req_way_r  <= repl_way;
      index_r    <= addr_index;
      hit_way_r  <= hit_way;
    end
  end

  // miss tracker is set by the request and cleared by completion
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      miss_r <= 1'b0;
    end else if (req_v_r) begin
      miss_r <= 1'b1;
    end else if (cache_req_complete_i) begin
      miss_r <= 1'b0;
    end
  end

  assign data_o           = data_r;
  assign data_v_o         = data_v_r;
  assign cache_req_v_o    = req_v_r;
  assign cache_req_addr_o = req_addr_r;
  assign cache_req_way_o  = req_way_r;
  assign miss_o           = miss_r;
  assign kill_o           = req_v_r;

  // every hit marks its way as most recently used
  assign lru_v_o     = data_v_r;
  assign lru_index_o = index_r;
  assign lru_way_o   = hit_way_r;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build the icache testbench with verilator, run it, and check the log
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -j 0 --top-module tb_icache -f filelist.f \
  -Mdir obj_dir -o sim_icache
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_icache > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$log"; then
  echo "simulation reported failure"
  exit 1
fi

exit 0

// File: tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache
  import icache_pkg::*;
();

  localparam int timeout_cycles = 40;
  localparam int quiet_cycles   = 12;
  localparam int fill_delay     = 3;

  // three tags that all land in set 3
  localparam logic [vaddr_width-1:0] va_a   = 16'h4530;
  localparam logic [ptag_width-1:0]  ptag_a = 8'h1a;
  localparam logic [vaddr_width-1:0] va_b   = 16'h7530;
  localparam logic [ptag_width-1:0]  ptag_b = 8'h2b;
  localparam logic [vaddr_width-1:0] va_c   = 16'h0930;
  localparam logic [ptag_width-1:0]  ptag_c = 8'h3c;

  logic                        clk_i;
  logic                        reset_i;
  logic                        fetch_v_i;
  logic [vaddr_width-1:0]      vaddr_i;
  logic                        fetch_ready_o;
  logic [ptag_width-1:0]       ptag_i;
  logic                        ptag_v_i;
  logic [word_width-1:0]       data_o;
  logic                        data_v_o;
  logic                        miss_o;
  logic                        cache_req_v_o;
  logic [block_addr_width-1:0] cache_req_addr_o;
  logic [way_width-1:0]        cache_req_way_o;
  logic                        cache_req_complete_i;
  logic                        fill_v_i;
  logic [index_width-1:0]      fill_index_i;
  logic [way_width-1:0]        fill_way_i;
  logic [tag_width-1:0]        fill_tag_i;
  logic [block_width-1:0]      fill_data_i;

  // backing memory with one entry per physical block
  logic [block_width-1:0] mem [2**block_addr_width];

  logic [word_width-1:0]       data_q [$];
  int                          data_cycle_q [$];
  logic [block_addr_width-1:0] req_addr_q [$];
  logic [way_width-1:0]        req_way_q [$];

  int cycle = 0;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  icache icache_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // record every response strobe with its cycle number
  initial begin
    forever begin
      @(negedge clk_i);
      cycle++;
      if (!reset_i && data_v_o) begin
        data_q.push_back(data_o);
        data_cycle_q.push_back(cycle);
      end
      if (!reset_i && cache_req_v_o) begin
        req_addr_q.push_back(cache_req_addr_o);
        req_way_q.push_back(cache_req_way_o);
      end
    end
  end

  // miss handler idles a few cycles, fills the whole block, then completes
  initial begin : miss_handler
    logic [block_addr_width-1:0] addr;
    logic [way_width-1:0]        way;
    fill_v_i             <= 1'b0;
    fill_index_i         <= '0;
    fill_way_i           <= '0;
    fill_tag_i           <= '0;
    fill_data_i          <= '0;
    cache_req_complete_i <= 1'b0;
    forever begin
      @(negedge clk_i);
      if (!reset_i && cache_req_v_o) begin
        addr = cache_req_addr_o;
        way  = cache_req_way_o;
        repeat (fill_delay) @(posedge clk_i);
        fill_v_i     <= 1'b1;
        fill_index_i <= addr[index_width-1:0];
        fill_way_i   <= way;
        fill_tag_i   <= addr[block_addr_width-1 -: tag_width];
        fill_data_i  <= mem[addr];
        @(posedge clk_i);
        fill_v_i             <= 1'b0;
        cache_req_complete_i <= 1'b1;
        @(posedge clk_i);
        cache_req_complete_i <= 1'b0;
      end
    end
  end

  // physical block address is the ptag over the page offset without its block offset
  function automatic logic [block_addr_width-1:0] block_addr_of(
    input logic [vaddr_width-1:0] va,
    input logic [ptag_width-1:0]  pt
  );
    return {pt, va[page_offset_width-1:block_offset_width]};
  endfunction

  function automatic logic [vaddr_width-1:0] word_addr(
    input logic [vaddr_width-1:0] base,
    input int                     w
  );
    return {base[vaddr_width-1:block_offset_width], word_sel_width'(w),
            word_offset_width'(0)};
  endfunction

  function automatic logic [word_width-1:0] expected_word(
    input logic [block_addr_width-1:0] ba,
    input int                          w
  );
    logic [block_width-1:0] blk;
    blk = mem[ba];
    return blk[w*word_width +: word_width];
  endfunction

  task automatic check_word(input string name, input logic [word_width-1:0] exp,
                            input logic [word_width-1:0] act);
    if (exp !== act) begin
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_block_addr(input string name, input logic [block_addr_width-1:0] exp,
                                  input logic [block_addr_width-1:0] act);
    if (exp !== act) begin
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_way(input string name, input logic [way_width-1:0] exp,
                           input logic [way_width-1:0] act);
    if (exp !== act) begin
      $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("mismatch %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic clear_responses();
    data_q.delete();
    data_cycle_q.delete();
    req_addr_q.delete();
    req_way_q.delete();
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic wait_ready(input string name);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!fetch_ready_o && n < timeout_cycles) begin
      @(negedge clk_i);
      n++;
    end
    if (!fetch_ready_o) begin
      $display("%s: fetch_ready_o stayed low past the timeout", name);
      errors++;
    end
  endtask

  task automatic wait_response(input string name, input int count);
    int n;
    n = 0;
    while (data_q.size() + req_addr_q.size() < count && n < timeout_cycles) begin
      @(posedge clk_i);
      n++;
    end
    if (data_q.size() + req_addr_q.size() < count) begin
      $display("%s: no response from the cache before the timeout", name);
      errors++;
    end
  endtask

  // fetch strobe followed by the translated tag one cycle later
  task automatic issue_fetch(input logic [vaddr_width-1:0] va,
                             input logic [ptag_width-1:0] pt, input logic pv);
    @(posedge clk_i);
    fetch_v_i <= 1'b1;
    vaddr_i   <= va;
    @(posedge clk_i);
    fetch_v_i <= 1'b0;
    ptag_v_i  <= pv;
    ptag_i    <= pt;
    @(posedge clk_i);
    ptag_v_i  <= 1'b0;
  endtask

  task automatic expect_hit(input string name, input logic [vaddr_width-1:0] va,
                            input logic [ptag_width-1:0] pt,
                            input logic [word_width-1:0] exp);
    wait_ready(name);
    clear_responses();
    issue_fetch(va, pt, 1'b1);
    wait_response(name, 1);
    if (req_addr_q.size() != 0) begin
      $display("%s: cache requested a refill where a hit was expected", name);
      errors++;
    end else if (data_q.size() != 0) begin
      check_word(name, exp, data_q[0]);
    end
    clear_responses();
  endtask

  task automatic expect_miss(input string name, input logic [vaddr_width-1:0] va,
                             input logic [ptag_width-1:0] pt,
                             input logic [block_addr_width-1:0] exp_addr,
                             input logic [way_width-1:0] exp_way);
    wait_ready(name);
    clear_responses();
    issue_fetch(va, pt, 1'b1);
    wait_response(name, 1);
    if (data_q.size() != 0) begin
      $display("%s: cache returned data where a miss was expected", name);
      errors++;
    end else if (req_addr_q.size() != 0) begin
      check_block_addr({name, " addr"}, exp_addr, req_addr_q[0]);
      check_way({name, " way"}, exp_way, req_way_q[0]);
    end
    clear_responses();
  endtask

  task automatic test_reset_and_first_miss();
    string name;
    int    errs;
    name = "reset_and_first_miss";
    errs = errors;
    @(negedge clk_i);
    check_bit({name, " data_v_o"}, 1'b0, data_v_o);
    check_bit({name, " cache_req_v_o"}, 1'b0, cache_req_v_o);
    check_bit({name, " miss_o"}, 1'b0, miss_o);
    check_bit({name, " fetch_ready_o"}, 1'b1, fetch_ready_o);
    expect_miss(name, va_a, ptag_a, block_addr_of(va_a, ptag_a), 1'b0);
    // tracker holds from the cycle after the request
    @(negedge clk_i);
    check_bit({name, " miss_o held"}, 1'b1, miss_o);
    check_bit({name, " fetch_ready_o held"}, 1'b0, fetch_ready_o);
    finish_test(name, errs);
  endtask

  task automatic test_block_hits();
    string name;
    int    errs;
    name = "block_hits";
    errs = errors;
    for (int w = 0; w < block_words; w++) begin
      expect_hit($sformatf("%s word %0d", name, w), word_addr(va_a, w), ptag_a,
                 expected_word(block_addr_of(va_a, ptag_a), w));
    end
    finish_test(name, errs);
  endtask

  task automatic test_second_tag();
    string name;
    int    errs;
    name = "second_tag";
    errs = errors;
    // way 1 still empty, so it wins over lru
    expect_miss(name, va_b, ptag_b, block_addr_of(va_b, ptag_b), 1'b1);
    expect_hit({name, " a"}, word_addr(va_a, 1), ptag_a,
               expected_word(block_addr_of(va_a, ptag_a), 1));
    expect_hit({name, " b"}, word_addr(va_b, 2), ptag_b,
               expected_word(block_addr_of(va_b, ptag_b), 2));
    finish_test(name, errs);
  endtask

  task automatic test_lru_replace();
    string name;
    int    errs;
    name = "lru_replace";
    errs = errors;
    expect_hit({name, " a first"}, va_a, ptag_a, expected_word(block_addr_of(va_a, ptag_a), 0));
    expect_miss({name, " c"}, va_c, ptag_c, block_addr_of(va_c, ptag_c), 1'b1);
    expect_hit({name, " c hit"}, word_addr(va_c, 3), ptag_c,
               expected_word(block_addr_of(va_c, ptag_c), 3));
    expect_hit({name, " a again"}, word_addr(va_a, 1), ptag_a,
               expected_word(block_addr_of(va_a, ptag_a), 1));
    // b was evicted by c
    expect_miss({name, " b"}, va_b, ptag_b, block_addr_of(va_b, ptag_b), 1'b1);
    expect_hit({name, " a kept"}, word_addr(va_a, 2), ptag_a,
               expected_word(block_addr_of(va_a, ptag_a), 2));
    // b most recent now, so the victim moves to way 0
    expect_hit({name, " b recent"}, word_addr(va_b, 0), ptag_b,
               expected_word(block_addr_of(va_b, ptag_b), 0));
    expect_miss({name, " c over a"}, va_c, ptag_c, block_addr_of(va_c, ptag_c), 1'b0);
    // put a back in way 0 for the later tests
    expect_miss({name, " a back"}, va_a, ptag_a, block_addr_of(va_a, ptag_a), 1'b0);
    finish_test(name, errs);
  endtask

  task automatic test_back_to_back();
    string name;
    int    errs;
    name = "back_to_back";
    errs = errors;
    wait_ready(name);
    clear_responses();
    @(posedge clk_i);
    fetch_v_i <= 1'b1;
    vaddr_i   <= word_addr(va_a, 3);
    @(posedge clk_i);
    vaddr_i   <= word_addr(va_b, 1);
    ptag_v_i  <= 1'b1;
    ptag_i    <= ptag_a;
    @(posedge clk_i);
    fetch_v_i <= 1'b0;
    ptag_i    <= ptag_b;
    @(posedge clk_i);
    ptag_v_i  <= 1'b0;
    wait_response(name, 2);
    if (req_addr_q.size() != 0) begin
      $display("%s: cache requested a refill where two hits were expected", name);
      errors++;
    end else if (data_q.size() == 2) begin
      check_word({name, " first"}, expected_word(block_addr_of(va_a, ptag_a), 3), data_q[0]);
      check_word({name, " second"}, expected_word(block_addr_of(va_b, ptag_b), 1), data_q[1]);
      check_bit({name, " consecutive"}, 1'b1, data_cycle_q[1] == data_cycle_q[0] + 1);
    end
    clear_responses();
    finish_test(name, errs);
  endtask

  task automatic test_dropped_fetch();
    string name;
    int    errs;
    name = "dropped_fetch";
    errs = errors;
    wait_ready(name);
    clear_responses();
    issue_fetch(va_a, ptag_a, 1'b0);
    repeat (quiet_cycles) @(posedge clk_i);
    check_bit({name, " data seen"}, 1'b0, data_q.size() != 0);
    check_bit({name, " request seen"}, 1'b0, req_addr_q.size() != 0);
    expect_hit({name, " after"}, va_a, ptag_a, expected_word(block_addr_of(va_a, ptag_a), 0));
    finish_test(name, errs);
  endtask

  initial begin
    reset_i   <= 1'b1;
    fetch_v_i <= 1'b0;
    vaddr_i   <= '0;
    ptag_i    <= '0;
    ptag_v_i  <= 1'b0;
    void'($urandom(16));
    for (int i = 0; i < 2**block_addr_width; i++) begin
      mem[block_addr_width'(i)] = {$urandom, $urandom, $urandom, $urandom};
    end
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;

    test_reset_and_first_miss();
    test_block_hits();
    test_second_tag();
    test_lru_replace();
    test_back_to_back();
    test_dropped_fetch();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
